// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FLIST     := flist.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

SOURCES   := $(shell cat $(FLIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_checker.sv ====
module tb_checker (
  input logic                              clk,
  input logic                              rstn,
  input logic                              access_request,
  input logic                              write,
  input logic [axi_pkg::axi_strb_bits-1:0] w_strb,
  input logic [axi_pkg::axi_addr_bits-1:0] addr,
  input logic [axi_pkg::axi_data_bits-1:0] data_in,
  input logic [axi_pkg::axi_data_bits-1:0] data_out,
  input logic                              stall,
  input logic                              error
);

  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;

  int unsigned error_count  = 0;
  int unsigned check_count  = 0;
  int unsigned test_errors  = 0;
  int unsigned test_count   = 0;
  int unsigned failed_tests = 0;
  int unsigned cycle_count;
  string       test_name    = "";

  // Cycle stamp for error lines
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  function automatic void count_error();
    error_count++;
    test_errors++;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    test_count++;
    if (test_errors == 0) begin
      $display("test %0s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %0s: %0d errors", test_name, test_errors);
    end
  endtask

  task automatic check_value(
    input string                    sig,
    input logic [axi_data_bits-1:0] expected,
    input logic [axi_data_bits-1:0] actual
  );
    check_count++;
    if (actual !== expected) begin
      count_error();
      $display("FAIL %0s expected %h actual %h", sig, expected, actual);
      $display("  cycle %0d req %b write %b addr %h strb %h data_in %h",
               cycle_count, access_request, write, addr, w_strb, data_in);
    end
  endtask

  // Outputs before any request has been made
  task automatic check_idle_outputs();
    check_value("stall", '0, stall);
    check_value("error", '0, error);
    check_value("data_out", '0, data_out);
  endtask

  task automatic compare_completion(
    input logic [axi_data_bits-1:0] exp_data,
    input logic                     exp_err
  );
    check_value("error", exp_err, error);
    check_value("data_out", exp_data, data_out);
  endtask

  task automatic note_timeout(input int unsigned limit);
    count_error();
    $display("ERROR: request to addr %h never completed within %0d cycles", addr, limit);
  endtask

  task automatic note_reset_stuck();
    count_error();
    $display("ERROR: reset was never released");
  endtask

  task automatic print_summary();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
  endtask

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for two cycles, released on the stimulus offset
  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

// ==== dv/tb_top.sv ====
module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;
  import mem_pkg::*;

  localparam int unsigned request_timeout = 50;
  localparam int unsigned reset_timeout   = 10;
  localparam int unsigned full_word_tests = 32;
  localparam int unsigned strobe_tests    = 32;
  localparam int unsigned mixed_tests     = 200;
  localparam int unsigned range_tests     = 8;

  logic                     clk;
  logic                     rstn;
  logic                     access_request;
  logic                     write;
  logic [axi_strb_bits-1:0] w_strb;
  logic [axi_addr_bits-1:0] addr;
  logic [axi_data_bits-1:0] data_in;
  logic [axi_data_bits-1:0] data_out;
  logic                     stall;
  logic                     error;

  // Reference memory cleared like the slave
  logic [axi_data_bits-1:0] model [mem_words];
  logic [axi_data_bits-1:0] last_read;
  integer                   seed;
  bit                       hung;

  tb_clk_gen clk_gen_i (
    .clk  (clk),
    .rstn (rstn)
  );

  cpu_bus_top cpu_bus_top_i (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .write          (write),
    .w_strb         (w_strb),
    .addr           (addr),
    .data_in        (data_in),
    .data_out       (data_out),
    .stall          (stall),
    .error          (error)
  );

  tb_checker checker_i (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .write          (write),
    .w_strb         (w_strb),
    .addr           (addr),
    .data_in        (data_in),
    .data_out       (data_out),
    .stall          (stall),
    .error          (error)
  );

  function automatic logic [axi_data_bits-1:0] merge_lanes(
    input logic [axi_data_bits-1:0] old_word,
    input logic [axi_data_bits-1:0] new_word,
    input logic [axi_strb_bits-1:0] strb
  );
    logic [axi_data_bits-1:0] result;
    result = old_word;
    for (int lane = 0; lane < axi_strb_bits; lane++) begin
      if (strb[lane]) begin
        result[8*lane +: 8] = new_word[8*lane +: 8];
      end
    end
    return result;
  endfunction

  // Word-aligned address inside the memory
  function automatic logic [axi_addr_bits-1:0] random_in_range();
    logic [axi_addr_bits-1:0] r;
    r = $random(seed);
    r = r % (mem_words * 4);
    return {r[axi_addr_bits-1:2], 2'b00};
  endfunction

  // Bit 10 set puts it at or beyond the end of memory
  function automatic logic [axi_addr_bits-1:0] random_out_of_range();
    logic [axi_addr_bits-1:0] r;
    r = $random(seed);
    return {r[axi_addr_bits-1:2], 2'b00} | axi_addr_bits'(mem_words * 4);
  endfunction

  // Returns on the stimulus offset of the completion cycle
  task automatic issue_request(
    input logic                     wr,
    input logic [axi_strb_bits-1:0] strb,
    input logic [axi_addr_bits-1:0] a,
    input logic [axi_data_bits-1:0] d
  );
    logic                     in_range;
    logic [axi_data_bits-1:0] exp_data;
    int unsigned              cycles;
    bit                       done;
    if (hung) begin
      return;
    end
    in_range = a < axi_addr_bits'(mem_words * 4);
    // A write leaves the last read word on data_out
    if (wr) begin
      exp_data = last_read;
    end else begin
      exp_data = in_range ? model[a[mem_index_bits+1:2]] : '0;
    end
    access_request = 1'b1;
    write          = wr;
    w_strb         = strb;
    addr           = a;
    data_in        = d;
    cycles         = 0;
    done           = 1'b0;
    while (!done && cycles < request_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
      done = !stall;
    end
    if (!done) begin
      checker_i.note_timeout(request_timeout);
      hung = 1'b1;
    end else begin
      checker_i.compare_completion(exp_data, !in_range);
      if (!wr) begin
        last_read = exp_data;
      end else if (in_range) begin
        model[a[mem_index_bits+1:2]] = merge_lanes(model[a[mem_index_bits+1:2]], d, strb);
      end
    end
  endtask

  task automatic go_idle();
    access_request = 1'b0;
    write          = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_reset();
    int unsigned cycles;
    cycles = 0;
    while (rstn !== 1'b1 && cycles < reset_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (rstn !== 1'b1) begin
      checker_i.note_reset_stuck();
      hung = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    logic [axi_addr_bits-1:0] a;
    logic [axi_data_bits-1:0] d;
    logic [axi_data_bits-1:0] rnd;
    seed           = 5;
    hung           = 1'b0;
    last_read      = '0;
    access_request = 1'b0;
    write          = 1'b0;
    w_strb         = '0;
    addr           = '0;
    data_in        = '0;
    for (int i = 0; i < mem_words; i++) begin
      model[i] = '0;
    end
    wait_reset();

    checker_i.start_test("reset_state");
    if (!hung) begin
      checker_i.check_idle_outputs();
    end
    checker_i.finish_test();

    checker_i.start_test("full_word_rw");
    for (int i = 0; i < full_word_tests; i++) begin
      a = random_in_range();
      d = $random(seed);
      issue_request(1'b1, '1, a, d);
      issue_request(1'b0, '1, a, '0);
    end
    go_idle();
    checker_i.finish_test();

    checker_i.start_test("strobe_merge");
    for (int i = 0; i < strobe_tests; i++) begin
      a   = random_in_range();
      d   = $random(seed);
      rnd = $random(seed);
      issue_request(1'b1, rnd[axi_strb_bits-1:0], a, d);
      issue_request(1'b0, '1, a, '0);
    end
    go_idle();
    checker_i.finish_test();

    // Each request is presented straight after the previous completion
    checker_i.start_test("back_to_back");
    for (int i = 0; i < mixed_tests; i++) begin
      a   = random_in_range();
      d   = $random(seed);
      rnd = $random(seed);
      issue_request(rnd[4], rnd[axi_strb_bits-1:0], a, d);
    end
    go_idle();
    checker_i.finish_test();

    checker_i.start_test("out_of_range");
    for (int i = 0; i < range_tests; i++) begin
      a   = random_out_of_range();
      d   = $random(seed);
      rnd = $random(seed);
      issue_request(1'b0, '1, a, '0);
      issue_request(1'b1, rnd[axi_strb_bits-1:0] | 4'h1, a, d);
      // Aliased in-range word must be untouched
      issue_request(1'b0, '1, a & axi_addr_bits'(mem_words * 4 - 1), '0);
      go_idle();
    end
    checker_i.finish_test();

    checker_i.print_summary();
    if (checker_i.error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/axi_pkg.sv
verilog/mem_pkg.sv
verilog/axi_master.sv
verilog/axi_mem_slave.sv
verilog/cpu_bus_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== verilog/axi_master.sv ====
module axi_master #(
  parameter logic [axi_pkg::axi_id_bits-1:0] master_id = '0
) (
  input  logic                               clk,
  input  logic                               rstn,
  // CPU side
  input  logic                               access_request,
  input  logic                               write,
  input  logic [axi_pkg::axi_strb_bits-1:0]  w_strb,
  input  logic [axi_pkg::axi_addr_bits-1:0]  addr,
  input  logic [axi_pkg::axi_data_bits-1:0]  data_in,
  output logic [axi_pkg::axi_data_bits-1:0]  data_out,
  output logic                               stall,
  output logic                               error,
  // Write address
  output logic [axi_pkg::axi_id_bits-1:0]    aw_id,
  output logic [axi_pkg::axi_addr_bits-1:0]  aw_addr,
  output logic [axi_pkg::axi_len_bits-1:0]   aw_len,
  output logic [axi_pkg::axi_size_bits-1:0]  aw_size,
  output axi_pkg::axi_burst_t                aw_burst,
  output logic                               aw_valid,
  input  logic                               aw_ready,
  // Write data
  output logic [axi_pkg::axi_data_bits-1:0]  w_data,
  output logic [axi_pkg::axi_strb_bits-1:0]  w_bus_strb,
  output logic                               w_last,
  output logic                               w_valid,
  input  logic                               w_ready,
  // Write response
  input  logic [axi_pkg::axi_id_bits-1:0]    b_id,
  input  axi_pkg::axi_resp_t                 b_resp,
  input  logic                               b_valid,
  output logic                               b_ready,
  // Read address
  output logic [axi_pkg::axi_id_bits-1:0]    ar_id,
  output logic [axi_pkg::axi_addr_bits-1:0]  ar_addr,
  output logic [axi_pkg::axi_len_bits-1:0]   ar_len,
  output logic [axi_pkg::axi_size_bits-1:0]  ar_size,
  output axi_pkg::axi_burst_t                ar_burst,
  output logic                               ar_valid,
  input  logic                               ar_ready,
  // Read data
  input  logic [axi_pkg::axi_id_bits-1:0]    r_id,
  input  logic [axi_pkg::axi_data_bits-1:0]  r_data,
  input  axi_pkg::axi_resp_t                 r_resp,
  input  logic                               r_last,
  input  logic                               r_valid,
  output logic                               r_ready
);

  import axi_pkg::*;
  import mem_pkg::*;

  master_state_t state, state_next, req_state;

  logic [axi_addr_bits-1:0] req_addr;
  logic [axi_data_bits-1:0] req_data;
  logic [axi_strb_bits-1:0] req_strb;
  logic [axi_data_bits-1:0] rdata_q;
  logic                     error_q;
  logic                     load_req;
  logic                     ar_hs, r_hs, aw_hs, w_hs, b_hs;

  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;
  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;

  // Where a pending CPU request goes next
  assign req_state = !access_request ? ms_idle : (write ? ms_aw : ms_ar);

  always_comb begin
    state_next = state;
    case (state)
      ms_idle: state_next = req_state;
      ms_ar:   state_next = ar_hs ? ms_r : ms_ar;
      ms_r:    state_next = r_hs ? req_state : ms_r;
      ms_aw:   state_next = aw_hs ? (w_hs ? ms_b : ms_w) : ms_aw;
      ms_w:    state_next = w_hs ? ms_b : ms_w;
      ms_b:    state_next = b_hs ? req_state : ms_b;
      default: state_next = ms_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ms_idle;
    end else begin
      state <= state_next;
    end
  end

  // Capture the request on entry to an address phase
  assign load_req = (state_next == ms_ar && state != ms_ar) ||
                    (state_next == ms_aw && state != ms_aw);

  always_ff @(posedge clk) begin
    if (load_req) begin
      req_addr <= addr;
      req_data <= data_in;
      req_strb <= w_strb;
    end
  end

  // Last read word and last response status
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_q <= '0;
      error_q <= 1'b0;
    end else if (r_hs) begin
      rdata_q <= r_data;
      error_q <= (r_resp != resp_okay);
    end else if (b_hs) begin
      error_q <= (b_resp != resp_okay);
    end
  end

  assign data_out = r_hs ? r_data : rdata_q;
  assign error    = r_hs ? (r_resp != resp_okay) :
                    b_hs ? (b_resp != resp_okay) : error_q;

  // Fixed single-beat attributes
  assign aw_id      = master_id;
  assign aw_addr    = req_addr;
  assign aw_len     = '0;
  assign aw_size    = axi_size_word;
  assign aw_burst   = burst_incr;
  assign w_data     = req_data;
  assign w_bus_strb = req_strb;
  assign w_last     = 1'b1;
  assign ar_id      = master_id;
  assign ar_addr    = req_addr;
  assign ar_len     = '0;
  assign ar_size    = axi_size_word;
  assign ar_burst   = burst_incr;

  always_comb begin
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    stall    = 1'b1;
    case (state)
      ms_idle: stall = access_request;
      ms_ar:   ar_valid = 1'b1;
      ms_r: begin
        r_ready = 1'b1;
        stall   = !r_hs;
      end
      ms_aw: begin
        aw_valid = 1'b1;
        // W follows in the AW transfer cycle
        w_valid  = aw_hs;
      end
      ms_w: begin
        w_valid = 1'b1;
        b_ready = 1'b1;
      end
      ms_b: begin
        b_ready = 1'b1;
        stall   = !b_hs;
      end
      default: stall = 1'b1;
    endcase
  end

  ar_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else $error("ar_valid dropped or ar_addr changed before ar_ready");

  aw_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
    else $error("aw_valid dropped or aw_addr changed before aw_ready");

  r_id_match: assert property (@(posedge clk) disable iff (!rstn)
    r_hs |-> r_id == master_id && r_last)
    else $error("R beat accepted with foreign ID or without r_last");

  b_id_match: assert property (@(posedge clk) disable iff (!rstn)
    b_hs |-> b_id == master_id)
    else $error("B response accepted with foreign ID");

endmodule

// ==== verilog/axi_mem_slave.sv ====
module axi_mem_slave (
  input  logic                               clk,
  input  logic                               rstn,
  // Write address
  input  logic [axi_pkg::axi_id_bits-1:0]    aw_id,
  input  logic [axi_pkg::axi_addr_bits-1:0]  aw_addr,
  input  logic [axi_pkg::axi_len_bits-1:0]   aw_len,
  input  logic [axi_pkg::axi_size_bits-1:0]  aw_size,
  input  axi_pkg::axi_burst_t                aw_burst,
  input  logic                               aw_valid,
  output logic                               aw_ready,
  // Write data
  input  logic [axi_pkg::axi_data_bits-1:0]  w_data,
  input  logic [axi_pkg::axi_strb_bits-1:0]  w_bus_strb,
  input  logic                               w_last,
  input  logic                               w_valid,
  output logic                               w_ready,
  // Write response
  output logic [axi_pkg::axi_id_bits-1:0]    b_id,
  output axi_pkg::axi_resp_t                 b_resp,
  output logic                               b_valid,
  input  logic                               b_ready,
  // Read address
  input  logic [axi_pkg::axi_id_bits-1:0]    ar_id,
  input  logic [axi_pkg::axi_addr_bits-1:0]  ar_addr,
  input  logic [axi_pkg::axi_len_bits-1:0]   ar_len,
  input  logic [axi_pkg::axi_size_bits-1:0]  ar_size,
  input  axi_pkg::axi_burst_t                ar_burst,
  input  logic                               ar_valid,
  output logic                               ar_ready,
  // Read data
  output logic [axi_pkg::axi_id_bits-1:0]    r_id,
  output logic [axi_pkg::axi_data_bits-1:0]  r_data,
  output axi_pkg::axi_resp_t                 r_resp,
  output logic                               r_last,
  output logic                               r_valid,
  input  logic                               r_ready
);

  import axi_pkg::*;
  import mem_pkg::*;

  slave_state_t state, state_next;

  logic [axi_data_bits-1:0]  mem [mem_words];
  logic [axi_data_bits-1:0]  rdata_q;
  logic [axi_id_bits-1:0]    id_q;
  logic [mem_index_bits-1:0] wr_index_q;
  axi_resp_t                 resp_q;
  logic                      ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic                      ar_in_range, aw_in_range;
  logic [mem_index_bits-1:0] ar_index;

  // Memory powers up cleared
  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
  end

  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;
  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;

  assign ar_in_range = ar_addr < axi_addr_bits'(mem_words * 4);
  assign aw_in_range = aw_addr < axi_addr_bits'(mem_words * 4);
  assign ar_index    = ar_addr[mem_index_bits+1:2];

  // Reads win when both address channels are valid
  assign ar_ready = (state == ss_idle);
  assign aw_ready = (state == ss_idle) && !ar_valid;
  assign w_ready  = (state == ss_wdata);
  assign r_valid  = (state == ss_rdata);
  assign b_valid  = (state == ss_bresp);

  always_comb begin
    state_next = state;
    case (state)
      ss_idle: begin
        if (ar_hs) begin
          state_next = ss_rdata;
        end else if (aw_hs) begin
          state_next = ss_wdata;
        end
      end
      ss_rdata: state_next = r_hs ? ss_idle : ss_rdata;
      ss_wdata: state_next = w_hs ? ss_bresp : ss_wdata;
      ss_bresp: state_next = b_hs ? ss_idle : ss_bresp;
      default:  state_next = ss_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ss_idle;
    end else begin
      state <= state_next;
    end
  end

  // Address phase captures ID, response and read word
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q    <= ar_id;
      resp_q  <= ar_in_range ? resp_okay : resp_slverr;
      rdata_q <= ar_in_range ? mem[ar_index] : '0;
    end else if (aw_hs) begin
      id_q       <= aw_id;
      resp_q     <= aw_in_range ? resp_okay : resp_slverr;
      wr_index_q <= aw_addr[mem_index_bits+1:2];
    end
  end

  // Byte lane merge, out-of-range writes dropped
  always_ff @(posedge clk) begin
    if (w_hs && resp_q == resp_okay) begin
      for (int b = 0; b < axi_strb_bits; b++) begin
        if (w_bus_strb[b]) begin
          mem[wr_index_q][8*b +: 8] <= w_data[8*b +: 8];
        end
      end
    end
  end

  assign r_id   = id_q;
  assign r_data = rdata_q;
  assign r_resp = resp_q;
  assign r_last = 1'b1;
  assign b_id   = id_q;
  assign b_resp = resp_q;

  single_beat_ar: assert property (@(posedge clk) disable iff (!rstn)
    ar_hs |-> ar_len == '0 && ar_size == axi_size_word && ar_burst == burst_incr)
    else $error("Read address is not a single-word INCR beat");

  single_beat_aw: assert property (@(posedge clk) disable iff (!rstn)
    aw_hs |-> aw_len == '0 && aw_size == axi_size_word && aw_burst == burst_incr)
    else $error("Write address is not a single-word INCR beat");

  w_last_set: assert property (@(posedge clk) disable iff (!rstn)
    w_hs |-> w_last)
    else $error("Single-beat write data without w_last");

  r_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    r_valid && !r_ready |=> r_valid && $stable(r_data))
    else $error("r_valid dropped or r_data changed before r_ready");

endmodule

// ==== verilog/axi_pkg.sv ====
package axi_pkg;

  // Bus widths
  localparam int unsigned axi_addr_bits = 32;
  localparam int unsigned axi_data_bits = 32;
  localparam int unsigned axi_strb_bits = 4;
  localparam int unsigned axi_id_bits   = 4;
  localparam int unsigned axi_len_bits  = 8;
  localparam int unsigned axi_size_bits = 3;

  // AxBURST encodings
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } axi_burst_t;

  // xRESP encodings
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_t;

  // AxSIZE code for 4 bytes per beat
  localparam logic [axi_size_bits-1:0] axi_size_word = 3'd2;

endpackage

// ==== verilog/cpu_bus_top.sv ====
module cpu_bus_top (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               access_request,
  input  logic                               write,
  input  logic [axi_pkg::axi_strb_bits-1:0]  w_strb,
  input  logic [axi_pkg::axi_addr_bits-1:0]  addr,
  input  logic [axi_pkg::axi_data_bits-1:0]  data_in,
  output logic [axi_pkg::axi_data_bits-1:0]  data_out,
  output logic                               stall,
  output logic                               error
);

  import axi_pkg::*;

  logic [axi_id_bits-1:0]   aw_id, b_id, ar_id, r_id;
  logic [axi_addr_bits-1:0] aw_addr, ar_addr;
  logic [axi_len_bits-1:0]  aw_len, ar_len;
  logic [axi_size_bits-1:0] aw_size, ar_size;
  axi_burst_t               aw_burst, ar_burst;
  logic [axi_data_bits-1:0] w_data, r_data;
  logic [axi_strb_bits-1:0] w_bus_strb;
  axi_resp_t                b_resp, r_resp;
  logic                     aw_valid, aw_ready, w_valid, w_ready, w_last;
  logic                     b_valid, b_ready, ar_valid, ar_ready;
  logic                     r_valid, r_ready, r_last;

  axi_master #(
    .master_id('0)
  ) axi_master_i (
    .clk            (clk),
    .rstn           (rstn),
    .access_request (access_request),
    .write          (write),
    .w_strb         (w_strb),
    .addr           (addr),
    .data_in        (data_in),
    .data_out       (data_out),
    .stall          (stall),
    .error          (error),
    .aw_id          (aw_id),
    .aw_addr        (aw_addr),
    .aw_len         (aw_len),
    .aw_size        (aw_size),
    .aw_burst       (aw_burst),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w_data         (w_data),
    .w_bus_strb     (w_bus_strb),
    .w_last         (w_last),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b_id           (b_id),
    .b_resp         (b_resp),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .ar_id          (ar_id),
    .ar_addr        (ar_addr),
    .ar_len         (ar_len),
    .ar_size        (ar_size),
    .ar_burst       (ar_burst),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .r_id           (r_id),
    .r_data         (r_data),
    .r_resp         (r_resp),
    .r_last         (r_last),
    .r_valid        (r_valid),
    .r_ready        (r_ready)
  );

  axi_mem_slave axi_mem_slave_i (
    .clk        (clk),
    .rstn       (rstn),
    .aw_id      (aw_id),
    .aw_addr    (aw_addr),
    .aw_len     (aw_len),
    .aw_size    (aw_size),
    .aw_burst   (aw_burst),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w_data     (w_data),
    .w_bus_strb (w_bus_strb),
    .w_last     (w_last),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b_id       (b_id),
    .b_resp     (b_resp),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .ar_id      (ar_id),
    .ar_addr    (ar_addr),
    .ar_len     (ar_len),
    .ar_size    (ar_size),
    .ar_burst   (ar_burst),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r_id       (r_id),
    .r_data     (r_data),
    .r_resp     (r_resp),
    .r_last     (r_last),
    .r_valid    (r_valid),
    .r_ready    (r_ready)
  );

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

  // Master sequencing, one outstanding transaction
  typedef enum logic [2:0] {
    ms_idle,
    ms_ar,
    ms_r,
    ms_aw,
    ms_w,
    ms_b
  } master_state_t;

  // Slave sequencing
  typedef enum logic [1:0] {
    ss_idle,
    ss_rdata,
    ss_wdata,
    ss_bresp
  } slave_state_t;

  // On-chip memory geometry
  localparam int unsigned mem_words      = 256;
  localparam int unsigned mem_index_bits = 8;

endpackage
